/* Makefile */
VERILATOR ?= verilator
TOP       ?= l2CacheTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* logic/coherenceCtrl.sv */
`timescale 1ns/1ps
/*
 * Coherence controller
 * Takes one L1 or snoop request at a time, runs the MESI transitions
 * and issues shared bus requests under its own credit count
 */
module coherenceCtrl
  import l2CachePkg::*;
(
  input  logic                          clk,
  input  logic                          rstN,
  // L1 request
  input  logic                          l1Valid,
  input  logic                          l1Op,
  input  logic [ADDR_WIDTH-1:0]         l1Addr,
  // Snooped request
  input  logic                          snoopValid,
  input  logic [1:0]                    snoopOp,
  input  logic [ADDR_WIDTH-1:0]         snoopAddr,
  // Shared bus return side
  input  logic                          busCredit,
  input  logic                          fillValid,
  input  logic                          fillShared,
  // Tag store and LRU results
  input  logic                          hit,
  input  logic [WAY_BITS-1:0]           hitWay,
  input  logic [1:0]                    hitState,
  input  logic [WAYS-1:0][TAG_BITS-1:0] wayTags,
  input  logic [WAYS-1:0][1:0]          wayStates,
  input  logic [WAY_BITS-1:0]           victimWay,
  // Tag store and LRU updates
  output cacheAddrT                     lookupAddr,
  output logic                          wrEn,
  output logic [WAY_BITS-1:0]           wrWay,
  output logic [TAG_BITS-1:0]           wrTag,
  output logic [1:0]                    wrState,
  output logic                          touch,
  output logic [WAY_BITS-1:0]           touchWay,
  // Responses and credits
  output logic                          l1RespValid,
  output logic                          l1RespHit,
  output logic                          l1Credit,
  output logic                          snoopRespValid,
  output logic [1:0]                    snoopResult,
  output logic                          snoopCredit,
  // Shared bus request
  output logic                          busValid,
  output logic [1:0]                    busOp,
  output logic [ADDR_WIDTH-1:0]         busAddr,
  // Statistics strobes
  output logic                          lookupStrobe,
  output logic                          lookupHit,
  output logic                          readStrobe,
  output logic                          writeStrobe
);

  logic [2:0]            state;
  // Requests parked while the FSM is busy
  logic                  l1Pend;
  logic                  l1PendOp;
  logic [ADDR_WIDTH-1:0] l1PendAddr;
  logic                  snPend;
  logic [1:0]            snPendOp;
  logic [ADDR_WIDTH-1:0] snPendAddr;
  // Request in service
  cacheAddrT             reqAddr;
  logic                  reqSnoop;
  logic                  reqL1Op;
  logic [1:0]            reqSnOp;
  logic [WAY_BITS-1:0]   wayQ;
  logic [1:0]            busCreditCnt;
  cacheAddrT             busLine;
  logic                  snReq;
  logic                  l1Req;
  logic                  hitM;
  logic                  busIssue;

  assign snReq      = snPend || snoopValid;
  assign l1Req      = l1Pend || l1Valid;
  assign hitM       = hit && hitState == MESI_M;
  assign lookupAddr = reqAddr;

  // Request payloads, no reset needed
  always_ff @(posedge clk) begin
    if (l1Valid) begin
      l1PendOp   <= l1Op;
      l1PendAddr <= l1Addr;
    end
    if (snoopValid) begin
      snPendOp   <= snoopOp;
      snPendAddr <= snoopAddr;
    end
    // Snoop wins over L1 when both wait
    if (state == ST_IDLE) begin
      if (snReq) begin
        reqAddr.raw <= snPend ? snPendAddr : snoopAddr;
        reqSnOp     <= snPend ? snPendOp : snoopOp;
      end else if (l1Req) begin
        reqAddr.raw <= l1Pend ? l1PendAddr : l1Addr;
        reqL1Op     <= l1Pend ? l1PendOp : l1Op;
      end
    end
    // Hit way for an upgrade, victim way for a fill
    if (state == ST_LOOKUP)
      wayQ <= hit ? hitWay : victimWay;
  end

  //**************************************************************************
  // Control FSM
  //**************************************************************************
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state          <= ST_IDLE;
      l1Pend         <= 1'b0;
      snPend         <= 1'b0;
      reqSnoop       <= 1'b0;
      busCreditCnt   <= 2'(BUS_CREDITS);
      l1RespValid    <= 1'b0;
      l1RespHit      <= 1'b0;
      snoopRespValid <= 1'b0;
      snoopResult    <= SNOOP_MISS;
    end else begin
      l1RespValid    <= 1'b0;
      snoopRespValid <= 1'b0;
      if (l1Valid)
        l1Pend <= 1'b1;
      if (snoopValid)
        snPend <= 1'b1;
      // One credit spent per issue, one back per busCredit pulse
      if (busValid && !busCredit)
        busCreditCnt <= busCreditCnt - 1'b1;
      else if (!busValid && busCredit)
        busCreditCnt <= busCreditCnt + 1'b1;
      case (state)
        ST_IDLE: begin
          if (snReq) begin
            snPend   <= 1'b0;
            reqSnoop <= 1'b1;
            state    <= ST_LOOKUP;
          end else if (l1Req) begin
            l1Pend   <= 1'b0;
            reqSnoop <= 1'b0;
            state    <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (reqSnoop) begin
            snoopRespValid <= 1'b1;
            snoopResult    <= !hit ? SNOOP_MISS : (hitM ? SNOOP_HITM : SNOOP_HIT);
            state          <= hitM ? ST_SNOOPWB : ST_IDLE;
          end else if (hit) begin
            // Hits answer now, an S write still owes an invalidate
            l1RespValid <= 1'b1;
            l1RespHit   <= 1'b1;
            if (reqL1Op == OP_WRITE && hitState == MESI_S)
              state <= ST_UPGRADE;
            else
              state <= ST_IDLE;
          end else begin
            state <= (wayStates[victimWay] == MESI_M) ? ST_EVICT : ST_FETCH;
          end
        end
        ST_EVICT: begin
          if (busValid)
            state <= ST_FETCH;
        end
        ST_FETCH: begin
          if (busValid)
            state <= ST_FILL;
        end
        ST_FILL: begin
          if (fillValid) begin
            l1RespValid <= 1'b1;
            l1RespHit   <= 1'b0;
            state       <= ST_IDLE;
          end
        end
        ST_UPGRADE, ST_SNOOPWB: begin
          if (busValid)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Tag store writes and LRU touches
  always_comb begin
    wrEn     = 1'b0;
    wrWay    = hitWay;
    wrTag    = reqAddr.f.tag;
    wrState  = hitState;
    touch    = 1'b0;
    touchWay = hitWay;
    case (state)
      ST_LOOKUP: begin
        if (hit && reqSnoop) begin
          // Snooped read shares the line, anything else takes it away
          wrEn    = 1'b1;
          wrState = (reqSnOp == BUS_READ) ? MESI_S : MESI_I;
        end else if (hit) begin
          touch = 1'b1;
          // Silent E to M upgrade
          if (reqL1Op == OP_WRITE && hitState == MESI_E) begin
            wrEn    = 1'b1;
            wrState = MESI_M;
          end
        end
      end
      ST_UPGRADE: begin
        wrEn    = busValid;
        wrWay   = wayQ;
        wrState = MESI_M;
      end
      ST_FILL: begin
        wrEn     = fillValid;
        wrWay    = wayQ;
        touch    = fillValid;
        touchWay = wayQ;
        if (reqL1Op == OP_WRITE)
          wrState = MESI_M;
        else
          wrState = fillShared ? MESI_S : MESI_E;
      end
      default: ;
    endcase
  end

  //**************************************************************************
  // Shared bus request
  //**************************************************************************
  assign busIssue = state == ST_EVICT || state == ST_FETCH ||
                    state == ST_UPGRADE || state == ST_SNOOPWB;
  // Held low under back-pressure
  assign busValid = busIssue && busCreditCnt != 2'd0;

  always_comb begin
    busLine          = reqAddr;
    busLine.f.offset = '0;
    busOp            = BUS_WB;
    case (state)
      // Victim line address comes from its stored tag
      ST_EVICT:   busLine.f.tag = wayTags[wayQ];
      ST_FETCH:   busOp = (reqL1Op == OP_WRITE) ? BUS_RFO : BUS_READ;
      ST_UPGRADE: busOp = BUS_INVAL;
      default: ;
    endcase
  end

  assign busAddr = busLine.raw;

  // Credits go back once a request fully retires
  assign l1Credit    = l1RespValid;
  assign snoopCredit = (snoopRespValid && snoopResult != SNOOP_HITM) ||
                       (state == ST_SNOOPWB && busValid);

  // Statistics
  assign lookupStrobe = state == ST_LOOKUP && !reqSnoop;
  assign lookupHit    = hit;
  assign readStrobe   = l1Valid && l1Op == OP_READ;
  assign writeStrobe  = l1Valid && l1Op == OP_WRITE;

endmodule

/* logic/l2Cache.sv */
`timescale 1ns/1ps
/*
 * L2 cache top level
 * 4-way MESI cache controller with tag store, LRU and statistics
 */
module l2Cache
  import l2CachePkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  l1Valid,
  input  logic                  l1Op,
  input  logic [ADDR_WIDTH-1:0] l1Addr,
  input  logic                  snoopValid,
  input  logic [1:0]            snoopOp,
  input  logic [ADDR_WIDTH-1:0] snoopAddr,
  input  logic                  busCredit,
  input  logic                  fillValid,
  input  logic                  fillShared,
  output logic                  l1RespValid,
  output logic                  l1RespHit,
  output logic                  l1Credit,
  output logic                  snoopRespValid,
  output logic [1:0]            snoopResult,
  output logic                  snoopCredit,
  output logic                  busValid,
  output logic [1:0]            busOp,
  output logic [ADDR_WIDTH-1:0] busAddr,
  output logic [31:0]           hitCount,
  output logic [31:0]           missCount,
  output logic [31:0]           readCount,
  output logic [31:0]           writeCount
);

  // Tag store interface
  cacheAddrT                     lookupAddr;
  logic                          wrEn;
  logic [WAY_BITS-1:0]           wrWay;
  logic [TAG_BITS-1:0]           wrTag;
  logic [1:0]                    wrState;
  logic                          hit;
  logic [WAY_BITS-1:0]           hitWay;
  logic [1:0]                    hitState;
  logic [WAYS-1:0][TAG_BITS-1:0] wayTags;
  logic [WAYS-1:0][1:0]          wayStates;
  // LRU interface
  logic                          touch;
  logic [WAY_BITS-1:0]           touchWay;
  logic [WAY_BITS-1:0]           victimWay;
  // Statistics strobes
  logic                          lookupStrobe;
  logic                          lookupHit;
  logic                          readStrobe;
  logic                          writeStrobe;

  coherenceCtrl ctrl (
    .clk, .rstN,
    .l1Valid, .l1Op, .l1Addr,
    .snoopValid, .snoopOp, .snoopAddr,
    .busCredit, .fillValid, .fillShared,
    .hit, .hitWay, .hitState, .wayTags, .wayStates, .victimWay,
    .lookupAddr, .wrEn, .wrWay, .wrTag, .wrState, .touch, .touchWay,
    .l1RespValid, .l1RespHit, .l1Credit,
    .snoopRespValid, .snoopResult, .snoopCredit,
    .busValid, .busOp, .busAddr,
    .lookupStrobe, .lookupHit, .readStrobe, .writeStrobe
  );

  tagStore tags (
    .clk, .rstN,
    .lookupAddr, .wrEn, .wrWay, .wrTag, .wrState,
    .hit, .hitWay, .hitState, .wayTags, .wayStates
  );

  // LRU follows the set of the request in service
  lruTracker lru (
    .clk, .rstN,
    .index     (lookupAddr.f.index),
    .touch, .touchWay, .wayStates, .victimWay
  );

  statCounters stats (
    .clk, .rstN,
    .lookupStrobe, .lookupHit, .readStrobe, .writeStrobe,
    .hitCount, .missCount, .readCount, .writeCount
  );

endmodule

/* logic/l2CachePkg.sv */
/*
 * L2 cache shared definitions
 * Geometry, MESI and snoop codes, bus operations, credits and FSM codes
 */
package l2CachePkg;

  //**************************************************************************
  // Geometry
  //**************************************************************************
  localparam int ADDR_WIDTH  = 32;
  localparam int OFFSET_BITS = 6;
  localparam int INDEX_BITS  = 4;
  localparam int TAG_BITS    = 22;
  localparam int WAYS        = 4;
  localparam int SETS        = 16;
  localparam int WAY_BITS    = 2;

  // Line states, I is zero so cleared storage reads as invalid
  localparam logic [1:0] MESI_I = 2'b00;
  localparam logic [1:0] MESI_S = 2'b01;
  localparam logic [1:0] MESI_E = 2'b10;
  localparam logic [1:0] MESI_M = 2'b11;

  // Snoop results as seen by the other caches
  localparam logic [1:0] SNOOP_MISS = 2'b00;
  localparam logic [1:0] SNOOP_HIT  = 2'b01;
  localparam logic [1:0] SNOOP_HITM = 2'b10;

  // L1 operations
  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  // Shared bus operations
  // On the snoop input BUS_WB stands for a snooped write
  localparam logic [1:0] BUS_READ  = 2'b00;
  localparam logic [1:0] BUS_RFO   = 2'b01;
  localparam logic [1:0] BUS_INVAL = 2'b10;
  localparam logic [1:0] BUS_WB    = 2'b11;

  // Initial credit counts per port
  localparam int L1_CREDITS    = 1;
  localparam int SNOOP_CREDITS = 1;
  localparam int BUS_CREDITS   = 2;

  //**************************************************************************
  // Controller FSM states
  //**************************************************************************
  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_LOOKUP  = 3'd1;
  localparam logic [2:0] ST_EVICT   = 3'd2;
  localparam logic [2:0] ST_FETCH   = 3'd3;
  localparam logic [2:0] ST_FILL    = 3'd4;
  localparam logic [2:0] ST_UPGRADE = 3'd5;
  localparam logic [2:0] ST_SNOOPWB = 3'd6;

  // Address word, seen either raw or split into its fields
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    struct packed {
      logic [TAG_BITS-1:0]    tag;
      logic [INDEX_BITS-1:0]  index;
      logic [OFFSET_BITS-1:0] offset;
    } f;
  } cacheAddrT;

endpackage

/* logic/lruTracker.sv */
`timescale 1ns/1ps
/*
 * LRU tracker
 * Age permutation per set, victim pick and age update on access
 */
module lruTracker
  import l2CachePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [INDEX_BITS-1:0] index,
  input  logic                 touch,
  input  logic [WAY_BITS-1:0]  touchWay,
  input  logic [WAYS-1:0][1:0] wayStates,
  output logic [WAY_BITS-1:0]  victimWay
);

  // Age 0 is most recent, WAYS-1 is the oldest
  logic [WAY_BITS-1:0] ages [SETS][WAYS];
  logic [WAY_BITS-1:0] touchAge;

  assign touchAge = ages[index][touchWay];

  // Oldest way first, then the lowest invalid way overrides it
  always_comb begin
    victimWay = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (ages[index][w] == WAY_BITS'(WAYS - 1))
        victimWay = WAY_BITS'(w);
    end
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (wayStates[w] == MESI_I)
        victimWay = WAY_BITS'(w);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      // Ages start equal to the way number
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++)
          ages[s][w] <= WAY_BITS'(w);
      end
    end else if (touch) begin
      for (int w = 0; w < WAYS; w++) begin
        if (WAY_BITS'(w) == touchWay)
          ages[index][w] <= '0;
        else if (ages[index][w] < touchAge)
          ages[index][w] <= ages[index][w] + 1'b1;
      end
    end
  end

endmodule

/* logic/statCounters.sv */
`timescale 1ns/1ps
/*
 * Statistics counters for L1 hits, misses, reads and writes
 */
module statCounters (
  input  logic        clk,
  input  logic        rstN,
  input  logic        lookupStrobe,
  input  logic        lookupHit,
  input  logic        readStrobe,
  input  logic        writeStrobe,
  output logic [31:0] hitCount,
  output logic [31:0] missCount,
  output logic [31:0] readCount,
  output logic [31:0] writeCount
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hitCount   <= '0;
      missCount  <= '0;
      readCount  <= '0;
      writeCount <= '0;
    end else begin
      // Each lookup is a hit or a miss
      if (lookupStrobe && lookupHit)
        hitCount <= hitCount + 1'b1;
      if (lookupStrobe && !lookupHit)
        missCount <= missCount + 1'b1;
      // Operations count on acceptance
      if (readStrobe)
        readCount <= readCount + 1'b1;
      if (writeStrobe)
        writeCount <= writeCount + 1'b1;
    end
  end

endmodule

/* logic/tagStore.sv */
`timescale 1ns/1ps
/*
 * Tag store
 * Tag and MESI state per way and set, with parallel tag compare
 */
module tagStore
  import l2CachePkg::*;
(
  input  logic                          clk,
  input  logic                          rstN,
  input  cacheAddrT                     lookupAddr,
  input  logic                          wrEn,
  input  logic [WAY_BITS-1:0]           wrWay,
  input  logic [TAG_BITS-1:0]           wrTag,
  input  logic [1:0]                    wrState,
  output logic                          hit,
  output logic [WAY_BITS-1:0]           hitWay,
  output logic [1:0]                    hitState,
  output logic [WAYS-1:0][TAG_BITS-1:0] wayTags,
  output logic [WAYS-1:0][1:0]          wayStates
);

  logic [TAG_BITS-1:0] tagMem   [SETS][WAYS];
  logic [1:0]          stateMem [SETS][WAYS];

  // Tags only matter once the state is valid
  always_ff @(posedge clk) begin
    if (wrEn)
      tagMem[lookupAddr.f.index][wrWay] <= wrTag;
  end

  // Every line starts invalid
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++)
          stateMem[s][w] <= MESI_I;
      end
    end else if (wrEn) begin
      stateMem[lookupAddr.f.index][wrWay] <= wrState;
    end
  end

  // Read out the whole indexed set
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      wayTags[w]   = tagMem[lookupAddr.f.index][w];
      wayStates[w] = stateMem[lookupAddr.f.index][w];
    end
  end

  // Compare all ways, an I line never matches
  always_comb begin
    hit    = 1'b0;
    hitWay = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (wayStates[w] != MESI_I && wayTags[w] == lookupAddr.f.tag) begin
        hit    = 1'b1;
        hitWay = WAY_BITS'(w);
      end
    end
  end

  assign hitState = wayStates[hitWay];

endmodule

/* tb.f */
logic/l2CachePkg.sv
logic/tagStore.sv
logic/lruTracker.sv
logic/coherenceCtrl.sv
logic/statCounters.sv
logic/l2Cache.sv
tests/l2CacheProps.sv
tests/l2CacheTb.sv

/* tests/l2CacheProps.sv */
`timescale 1ns/1ps
/*
 * Protocol assertions for the L2 cache, bound into its top level
 */
module l2CacheProps
  import l2CachePkg::*;
(
  input logic       clk,
  input logic       rstN,
  input logic       l1Valid,
  input logic       l1RespValid,
  input logic       l1RespHit,
  input logic       l1Credit,
  input logic       snoopValid,
  input logic       snoopRespValid,
  input logic       busValid,
  input logic       busCredit,
  input logic [2:0] ctrlState
);

  // Requests issued and not yet paid back by busCredit
  logic [2:0] outstanding;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      outstanding <= '0;
    else
      outstanding <= outstanding + 3'(busValid) - 3'(busCredit);
  end

  busLimit: assert property (@(posedge clk) disable iff (!rstN)
    outstanding <= 3'(BUS_CREDITS)) else $error("bus credit limit exceeded");

  respCredit: assert property (@(posedge clk) disable iff (!rstN)
    l1RespValid |-> l1Credit) else $error("L1 response without credit");

  // An idle controller takes the snoop at once
  snoopLatency: assert property (@(posedge clk) disable iff (!rstN)
    snoopValid && ctrlState == ST_IDLE |=> ##1 snoopRespValid)
    else $error("snoop response latency");

  // A hit answers two edges after its request was sampled
  hitLatency: assert property (@(posedge clk) disable iff (!rstN)
    l1RespValid && l1RespHit |-> $past(l1Valid, 2))
    else $error("L1 hit response latency");

  quietReset: assert property (@(posedge clk)
    !rstN |-> !l1RespValid && !snoopRespValid && !busValid)
    else $error("valid output during reset");

endmodule

bind l2Cache l2CacheProps props (.*, .ctrlState(ctrl.state));

/* tests/l2CacheTb.sv */
`timescale 1ns/1ps
/*
 * L2 cache testbench
 * Credit-based L1 and snoop stimulus, bus responder and a line-state model
 */
module l2CacheTb
  import l2CachePkg::*;
();

  logic        clk = 1'b0;
  logic        rstN;
  logic        l1Valid;
  logic        l1Op;
  logic [31:0] l1Addr;
  logic        snoopValid;
  logic [1:0]  snoopOp;
  logic [31:0] snoopAddr;
  logic        busCredit;
  logic        fillValid;
  logic        fillShared;
  logic        l1RespValid;
  logic        l1RespHit;
  logic        l1Credit;
  logic        snoopRespValid;
  logic [1:0]  snoopResult;
  logic        snoopCredit;
  logic        busValid;
  logic [1:0]  busOp;
  logic [31:0] busAddr;
  logic [31:0] hitCount;
  logic [31:0] missCount;
  logic [31:0] readCount;
  logic [31:0] writeCount;

  // Line-state model, ages 0 is most recent
  logic [21:0] mTag   [SETS][WAYS];
  logic [1:0]  mState [SETS][WAYS];
  logic [1:0]  mAge   [SETS][WAYS];
  int          mHits;
  int          mMisses;
  int          mReads;
  int          mWrites;
  logic        expHit;
  logic [1:0]  expSnoop;
  logic [1:0]  expOps[$];
  logic [31:0] expAddrs[$];
  // Bus side
  logic [1:0]  busOps[$];
  logic [31:0] busAddrs[$];
  logic        busPause;
  logic        shareNext;
  int          creditsOwed;
  int          fillWait;
  int          pausedIssues;
  // Credits held by the L1 and snoop drivers
  int          l1Cred;
  int          snoopCred;
  int          reqCount;
  int          valueErrors;
  int          otherErrors;
  int          cycles;
  logic [21:0] tags4 [5];

  l2Cache DUT (.*);

  always #4 clk = ~clk;

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic expectEqual(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      valueErrors++;
    end
  endtask

  task automatic finishRun();
    $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  endtask

  //**************************************************************************
  // Model
  //**************************************************************************
  function automatic logic [31:0] lineAddr(logic [21:0] tag, int idx);
    return {tag, 4'(idx), 6'b0};
  endfunction

  // Low bits keep tags distinct within one test
  function automatic logic [21:0] pickTag(int k);
    logic [31:0] r;
    r = $urandom();
    return {r[18:0], 3'(k)};
  endfunction

  // Way holding the line, -1 when absent
  function automatic int findWay(logic [31:0] addr);
    int way;
    way = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (mState[addr[9:6]][w] != MESI_I && mTag[addr[9:6]][w] == addr[31:10])
        way = w;
    end
    return way;
  endfunction

  // Invalid ways are used first, in order, then the oldest
  function automatic int pickVictim(int idx);
    for (int w = 0; w < WAYS; w++) begin
      if (mState[idx][w] == MESI_I)
        return w;
    end
    for (int w = 0; w < WAYS; w++) begin
      if (mAge[idx][w] == 2'(WAYS - 1))
        return w;
    end
    return 0;
  endfunction

  function automatic void touchWay(int idx, int way);
    logic [1:0] old;
    old = mAge[idx][way];
    for (int w = 0; w < WAYS; w++) begin
      if (w == way)
        mAge[idx][w] = 2'd0;
      else if (mAge[idx][w] < old)
        mAge[idx][w] = mAge[idx][w] + 2'd1;
    end
  endfunction

  function automatic void expectBus(logic [1:0] op, logic [31:0] addr);
    expOps.push_back(op);
    expAddrs.push_back(addr);
  endfunction

  // Predicts response and bus traffic of an L1 access, then updates the model
  function automatic void applyL1(logic op, logic [31:0] addr, logic shared);
    int idx;
    int way;
    idx       = int'(addr[9:6]);
    way       = findWay(addr);
    expHit    = way >= 0;
    shareNext = shared;
    if (op == OP_READ)
      mReads++;
    else
      mWrites++;
    if (way >= 0) begin
      mHits++;
      if (op == OP_WRITE && mState[idx][way] == MESI_S)
        expectBus(BUS_INVAL, {addr[31:6], 6'b0});
      if (op == OP_WRITE)
        mState[idx][way] = MESI_M;
    end else begin
      mMisses++;
      way = pickVictim(idx);
      // Dirty victim goes out before the fill request
      if (mState[idx][way] == MESI_M)
        expectBus(BUS_WB, lineAddr(mTag[idx][way], idx));
      expectBus(op == OP_WRITE ? BUS_RFO : BUS_READ, {addr[31:6], 6'b0});
      mTag[idx][way]   = addr[31:10];
      mState[idx][way] = (op == OP_WRITE) ? MESI_M : (shared ? MESI_S : MESI_E);
    end
    touchWay(idx, way);
  endfunction

  // Snoops never touch the ages
  function automatic void applySnoop(logic [1:0] op, logic [31:0] addr);
    int way;
    way = findWay(addr);
    if (way < 0) begin
      expSnoop = SNOOP_MISS;
    end else begin
      if (mState[addr[9:6]][way] == MESI_M) begin
        expSnoop = SNOOP_HITM;
        expectBus(BUS_WB, {addr[31:6], 6'b0});
      end else begin
        expSnoop = SNOOP_HIT;
      end
      mState[addr[9:6]][way] = (op == BUS_READ) ? MESI_S : MESI_I;
    end
  endfunction

  //**************************************************************************
  // Drivers and response checks
  //**************************************************************************
  task automatic sendL1(logic op, logic [31:0] addr);
    int n;
    n = 0;
    while (l1Cred == 0 && n < 100) begin
      tick();
      n++;
    end
    if (l1Cred == 0) begin
      $display("L1 credit was never returned");
      otherErrors++;
    end
    l1Valid = 1'b1;
    l1Op    = op;
    l1Addr  = addr;
    l1Cred--;
    reqCount++;
    tick();
    l1Valid = 1'b0;
  endtask

  task automatic sendSnoop(logic [1:0] op, logic [31:0] addr);
    int n;
    n = 0;
    while (snoopCred == 0 && n < 100) begin
      tick();
      n++;
    end
    if (snoopCred == 0) begin
      $display("Snoop credit was never returned");
      otherErrors++;
    end
    snoopValid = 1'b1;
    snoopOp    = op;
    snoopAddr  = addr;
    snoopCred--;
    reqCount++;
    tick();
    snoopValid = 1'b0;
  endtask

  task automatic waitL1Resp();
    int n;
    n = 0;
    while (!l1RespValid && n < 400) begin
      tick();
      n++;
    end
    if (!l1RespValid) begin
      $display("No L1 response arrived");
      otherErrors++;
    end else begin
      expectEqual("l1RespHit", l1RespHit, expHit);
    end
    tick();
  endtask

  task automatic waitSnoopResp();
    int n;
    n = 0;
    while (!snoopRespValid && n < 100) begin
      tick();
      n++;
    end
    if (!snoopRespValid) begin
      $display("No snoop response arrived");
      otherErrors++;
    end else begin
      expectEqual("snoopResult", snoopResult, expSnoop);
    end
    tick();
  endtask

  // Compares the logged bus requests with the predicted ones, in order
  task automatic checkBus();
    int n;
    n = 0;
    while (busOps.size() < expOps.size() && n < 200) begin
      tick();
      n++;
    end
    if (busOps.size() < expOps.size()) begin
      $display("An expected bus request was never issued");
      otherErrors++;
    end
    while (expOps.size() > 0 && busOps.size() > 0) begin
      expectEqual("busOp", busOps.pop_front(), expOps.pop_front());
      expectEqual("busAddr", busAddrs.pop_front(), expAddrs.pop_front());
    end
    if (busOps.size() > 0) begin
      $display("The cache issued a bus request that was not expected");
      otherErrors++;
    end
    busOps.delete();
    busAddrs.delete();
    expOps.delete();
    expAddrs.delete();
  endtask

  task automatic runL1(logic op, logic [31:0] addr, logic shared);
    applyL1(op, addr, shared);
    sendL1(op, addr);
    waitL1Resp();
    checkBus();
  endtask

  task automatic runSnoop(logic [1:0] op, logic [31:0] addr);
    applySnoop(op, addr);
    sendSnoop(op, addr);
    waitSnoopResp();
    checkBus();
  endtask

  // Bus responder, logs requests at the edge and answers 1 ns later
  always @(posedge clk) begin
    if (rstN && busValid) begin
      busOps.push_back(busOp);
      busAddrs.push_back(busAddr);
      creditsOwed++;
      if (busPause)
        pausedIssues++;
      if (busOp == BUS_READ || busOp == BUS_RFO)
        fillWait = 3;
    end
    #1;
    busCredit = 1'b0;
    fillValid = 1'b0;
    if (!busPause && creditsOwed > 0) begin
      busCredit = 1'b1;
      creditsOwed--;
    end
    if (fillWait > 0) begin
      fillWait = fillWait - 1;
      if (fillWait == 0) begin
        fillValid  = 1'b1;
        fillShared = shareNext;
      end
    end
  end

  // Credits come back at the end of the cycle that carries them
  always @(posedge clk) begin
    if (rstN && l1Credit)
      l1Cred++;
    if (rstN && snoopCredit)
      snoopCred++;
  end

  // Watchdog, 200 cycles per issued request
  initial begin
    cycles = 0;
    while (cycles <= 200 * (reqCount + 1) + 10) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, the cache stopped making progress");
    otherErrors++;
    finishRun();
  end

  //**************************************************************************
  // Test sequence
  //**************************************************************************
  initial begin
    rstN       = 1'b0;
    l1Valid    = 1'b0;
    l1Op       = OP_READ;
    l1Addr     = '0;
    snoopValid = 1'b0;
    snoopOp    = BUS_READ;
    snoopAddr  = '0;
    busCredit  = 1'b0;
    fillValid  = 1'b0;
    fillShared = 1'b0;
    busPause   = 1'b0;
    shareNext  = 1'b0;
    l1Cred     = L1_CREDITS;
    snoopCred  = SNOOP_CREDITS;
    void'($urandom(32'h6ade1b14));
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        mTag[s][w]   = '0;
        mState[s][w] = MESI_I;
        mAge[s][w]   = 2'(w);
      end
    end
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    tick();

    // Exclusive fill, read hit, silent E to M
    tags4[0] = pickTag(0);
    runL1(OP_READ, lineAddr(tags4[0], 1) | ($urandom() & 32'h3f), 1'b0);
    runL1(OP_READ, lineAddr(tags4[0], 1), 1'b0);
    runL1(OP_WRITE, lineAddr(tags4[0], 1) | 32'h3c, 1'b0);

    // Shared fill, invalidate on write, snooped reads and write
    tags4[1] = pickTag(1);
    runL1(OP_READ, lineAddr(tags4[1], 2) | 32'h08, 1'b1);
    runL1(OP_WRITE, lineAddr(tags4[1], 2), 1'b0);
    runSnoop(BUS_READ, lineAddr(tags4[1], 2));
    runSnoop(BUS_READ, lineAddr(tags4[1], 2) | 32'h10);
    runSnoop(BUS_WB, lineAddr(tags4[1], 2));

    // RFO, snooped invalidate of an M line, then a miss and a snoop miss
    tags4[2] = pickTag(2);
    runL1(OP_WRITE, lineAddr(tags4[2], 3), 1'b0);
    runSnoop(BUS_INVAL, lineAddr(tags4[2], 3));
    runL1(OP_READ, lineAddr(tags4[2], 3), 1'b0);
    runSnoop(BUS_READ, lineAddr(pickTag(7), 3));

    // Five tags in one set force an eviction of a dirty way
    for (int k = 0; k < 5; k++) begin
      tags4[k] = pickTag(k);
      runL1((k == 0 || k == 2) ? OP_WRITE : OP_READ, lineAddr(tags4[k], 4), k == 3);
    end
    runL1(OP_READ, lineAddr(tags4[0], 4), 1'b0);
    for (int k = 0; k < 8; k++)
      runL1(1'($urandom()), lineAddr(tags4[$urandom() % 5], 4), 1'($urandom()));

    // Withheld bus credits stall the third miss
    busPause     = 1'b1;
    pausedIssues = 0;
    runL1(OP_READ, lineAddr(pickTag(0), 5), 1'b0);
    runL1(OP_READ, lineAddr(pickTag(1), 5), 1'b0);
    tags4[0] = pickTag(2);
    applyL1(OP_READ, lineAddr(tags4[0], 5), 1'b0);
    sendL1(OP_READ, lineAddr(tags4[0], 5));
    repeat (30) begin
      tick();
      expectEqual("busValid", busValid, 32'd0);
      expectEqual("l1RespValid", l1RespValid, 32'd0);
    end
    expectEqual("pausedIssues", pausedIssues, BUS_CREDITS);
    busPause = 1'b0;
    waitL1Resp();
    checkBus();

    // Counters settle one edge after their strobes
    repeat (4) tick();
    expectEqual("hitCount", hitCount, mHits);
    expectEqual("missCount", missCount, mMisses);
    expectEqual("readCount", readCount, mReads);
    expectEqual("writeCount", writeCount, mWrites);
    finishRun();
  end

endmodule
